// ==== hw/mixer_config.svh ====
// ------------------------------------------------
// motor mixer configuration. bus widths, rate format,
// thrust bias and the motor rate mapping window.
// ------------------------------------------------
`ifndef MIXER_CONFIG_SVH
`define MIXER_CONFIG_SVH

// apb bus.
`define APB_ADDR_W 8       // byte address width.
`define APB_DATA_W 32      // data word width.

// rate format.
`define MIXER_RATE_W 16    // q12.4 signed rate word.
`define MIXER_FRAC_BITS 4  // fraction bits of a rate word.
`define MOTOR_RATE_W 8     // unsigned motor rate.

// thrust and mapping.
`define MOTOR_RATE_BIAS 16'h0100          // idle bias, 16.0 in q12.4.
`define MAP_ROUND_VAL 8                   // half an lsb of the motor rate.
`define MAP_SHIFT `MIXER_FRAC_BITS        // drop the fraction bits.

// legal motor window, inclusive.
`define MOTOR_VAL_MIN 10
`define MOTOR_VAL_MAX 240

`endif

// ==== hw/mixer_pkg.sv ====
// ------------------------------------------------
// motor mixer types and register map.
// ------------------------------------------------
`include "mixer_config.svh"

package mixer_pkg;

  typedef logic signed [`MIXER_RATE_W-1:0] rate_t;   // q12.4 signed rate.
  typedef logic [`MOTOR_RATE_W-1:0] motor_rate_t;    // unsigned motor rate.

  // ------------------------------------------------
  // bundles.
  typedef struct packed {
    rate_t yaw;
    rate_t roll;
    rate_t pitch;
    rate_t throttle;
  } rate_cmd_t;                                      // one committed command.

  typedef struct packed {
    rate_t m1;
    rate_t m2;
    rate_t m3;
    rate_t m4;
  } attitude_mix_t;                                  // per-motor attitude term.

  typedef struct packed {
    motor_rate_t m1;
    motor_rate_t m2;
    motor_rate_t m3;
    motor_rate_t m4;
  } motor_rates_t;                                   // m1 sits in the top byte.

  // ------------------------------------------------
  // register map.
  localparam logic [`APB_ADDR_W-1:0] REG_YAW      = 8'h00;
  localparam logic [`APB_ADDR_W-1:0] REG_ROLL     = 8'h04;
  localparam logic [`APB_ADDR_W-1:0] REG_PITCH    = 8'h08;
  localparam logic [`APB_ADDR_W-1:0] REG_THROTTLE = 8'h0C;
  localparam logic [`APB_ADDR_W-1:0] REG_CTRL     = 8'h10;
  localparam logic [`APB_ADDR_W-1:0] REG_MOTORS   = 8'h14;  // read only.

  localparam int CTRL_ARM_BIT    = 0;
  localparam int CTRL_COMMIT_BIT = 1;                // write-only pulse.

endpackage

// ==== hw/mixer_apb_regs.sv ====
// ------------------------------------------------
// apb slave for the motor mixer. holds the rate words
// and arm bit, fires the commit pulse, reads back motors.
// ------------------------------------------------
`timescale 1ns/10ps
`include "mixer_config.svh"

module mixer_apb_regs (
  input  logic                     sys_clk,
  input  logic                     rst_n,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`APB_ADDR_W-1:0]   paddr,
  input  logic [`APB_DATA_W-1:0]   pwdata,
  output logic [`APB_DATA_W-1:0]   prdata,
  output logic                     pready,
  output logic                     pslverr,
  input  mixer_pkg::motor_rates_t  motor_rates,
  output mixer_pkg::rate_cmd_t     cmd,
  output logic                     cmd_valid,
  output logic                     armed
);
  import mixer_pkg::*;

  logic access;      // apb access phase.
  logic wr_access;
  logic hit_yaw;
  logic hit_roll;
  logic hit_pitch;
  logic hit_throttle;
  logic hit_ctrl;
  logic hit_motors;
  logic hit_any;
  logic commit_wr;   // ctrl write with the commit bit set.
  logic arm_bit;     // arm bit as last written.

  // sign extend a rate word onto the data bus.
  function automatic logic [`APB_DATA_W-1:0] sext(input rate_t r);
    return {{(`APB_DATA_W-`MIXER_RATE_W){r[`MIXER_RATE_W-1]}}, r};
  endfunction

  // ------------------------------------------------
  // decode.
  assign access       = psel & penable;
  assign wr_access    = access & pwrite;
  assign hit_yaw      = (paddr == REG_YAW);
  assign hit_roll     = (paddr == REG_ROLL);
  assign hit_pitch    = (paddr == REG_PITCH);
  assign hit_throttle = (paddr == REG_THROTTLE);
  assign hit_ctrl     = (paddr == REG_CTRL);
  assign hit_motors   = (paddr == REG_MOTORS);
  assign hit_any      = hit_yaw | hit_roll | hit_pitch | hit_throttle | hit_ctrl | hit_motors;

  assign pready    = 1'b1;                                    // no wait states.
  assign pslverr   = access & (~hit_any | (pwrite & hit_motors));  // unmapped or read only.
  assign commit_wr = wr_access & hit_ctrl & pwdata[CTRL_COMMIT_BIT];

  // ------------------------------------------------
  // register writes.
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd     <= '0;
      arm_bit <= 1'b0;
    end else if (wr_access) begin
      if (hit_yaw)      cmd.yaw      <= pwdata[`MIXER_RATE_W-1:0];
      if (hit_roll)     cmd.roll     <= pwdata[`MIXER_RATE_W-1:0];
      if (hit_pitch)    cmd.pitch    <= pwdata[`MIXER_RATE_W-1:0];
      if (hit_throttle) cmd.throttle <= pwdata[`MIXER_RATE_W-1:0];
      if (hit_ctrl)     arm_bit      <= pwdata[CTRL_ARM_BIT];
    end
  end

  // commit pulse. armed follows the arm bit only at a commit.
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_valid <= 1'b0;
      armed     <= 1'b0;
    end else begin
      cmd_valid <= commit_wr;                   // one cycle pulse.
      if (commit_wr) armed <= pwdata[CTRL_ARM_BIT];
    end
  end

  // ------------------------------------------------
  // read mux.
  always_comb begin
    prdata = '0;
    case (paddr)
      REG_YAW:      prdata = sext(cmd.yaw);
      REG_ROLL:     prdata = sext(cmd.roll);
      REG_PITCH:    prdata = sext(cmd.pitch);
      REG_THROTTLE: prdata = sext(cmd.throttle);
      REG_CTRL:     prdata[CTRL_ARM_BIT] = arm_bit;   // commit reads as 0.
      REG_MOTORS:   prdata = motor_rates;
      default:      prdata = '0;
    endcase
  end

endmodule

// ==== hw/attitude_mixer.sv ====
// ------------------------------------------------
// attitude mixer. x frame per-motor sum of the halved
// yaw, roll and pitch terms, registered on commit.
// ------------------------------------------------
`timescale 1ns/10ps

module attitude_mixer (
  input  logic                     sys_clk,
  input  logic                     rst_n,
  input  mixer_pkg::rate_cmd_t     cmd,
  input  logic                     cmd_valid,
  output mixer_pkg::attitude_mix_t att_mix,
  output logic                     att_valid
);
  import mixer_pkg::*;

  rate_t yaw_h;     // yaw / 2.
  rate_t roll_h;    // roll / 2.
  rate_t pitch_h;   // pitch / 2.

  // arithmetic halving keeps the sign.
  assign yaw_h   = $signed(cmd.yaw) >>> 1;
  assign roll_h  = $signed(cmd.roll) >>> 1;
  assign pitch_h = $signed(cmd.pitch) >>> 1;

  // ------------------------------------------------
  // mix. m1, m4 ccw and m2, m3 cw; sums wrap in 16 bits.
  always_ff @(posedge sys_clk) begin
    if (cmd_valid) begin
      att_mix.m1 <= -yaw_h + roll_h - pitch_h;   // front left.
      att_mix.m2 <=  yaw_h - roll_h - pitch_h;   // front right.
      att_mix.m3 <=  yaw_h + roll_h + pitch_h;   // rear left.
      att_mix.m4 <= -yaw_h - roll_h + pitch_h;   // rear right.
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      att_valid <= 1'b0;
    end else begin
      att_valid <= cmd_valid;                    // one cycle behind commit.
    end
  end

endmodule

// ==== hw/collective_thrust.sv ====
// ------------------------------------------------
// collective thrust. throttle plus idle bias, saturated.
// ------------------------------------------------
`timescale 1ns/10ps
`include "mixer_config.svh"

module collective_thrust (
  input  logic                 sys_clk,
  input  logic                 rst_n,
  input  mixer_pkg::rate_cmd_t cmd,
  input  logic                 cmd_valid,
  output mixer_pkg::rate_t     thrust,
  output logic                 thrust_valid
);
  import mixer_pkg::*;

  localparam rate_t BIAS = `MOTOR_RATE_BIAS;  // bias as a signed rate word.

  logic signed [`MIXER_RATE_W:0]   sum_ext;   // one guard bit.
  rate_t                           sat;

  assign sum_ext = $signed(cmd.throttle) + BIAS;

  // overflow when the guard bit and sign bit disagree.
  always_comb begin
    if (sum_ext[`MIXER_RATE_W] != sum_ext[`MIXER_RATE_W-1]) begin
      sat = sum_ext[`MIXER_RATE_W] ? {1'b1, {(`MIXER_RATE_W-1){1'b0}}}   // clamp low.
                                   : {1'b0, {(`MIXER_RATE_W-1){1'b1}}};  // clamp high.
    end else begin
      sat = sum_ext[`MIXER_RATE_W-1:0];
    end
  end

  always_ff @(posedge sys_clk) begin
    if (cmd_valid) thrust <= sat;
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) thrust_valid <= 1'b0;
    else        thrust_valid <= cmd_valid;
  end

endmodule

// ==== hw/motor_output_mapper.sv ====
// ------------------------------------------------
// motor output mapper. thrust plus attitude, rounded and
// narrowed to 8 bits, windowed with last legal hold.
// ------------------------------------------------
`timescale 1ns/10ps
`include "mixer_config.svh"

module motor_output_mapper (
  input  logic                     sys_clk,
  input  logic                     rst_n,
  input  mixer_pkg::attitude_mix_t att_mix,
  input  logic                     att_valid,
  input  mixer_pkg::rate_t         thrust,
  input  logic                     armed,
  output mixer_pkg::motor_rates_t  motor_rates,
  output logic                     rates_valid
);
  import mixer_pkg::*;

  localparam int MAP_W = `MIXER_RATE_W + 2;   // 18 bit sum, no overflow.

  // map one motor. out of window returns the last legal rate.
  function automatic motor_rate_t map_motor(
    input rate_t       thr,
    input rate_t       att,
    input motor_rate_t last
  );
    logic signed [MAP_W-1:0] sum;
    logic signed [MAP_W-1:0] scaled;
    sum    = MAP_W'(thr) + MAP_W'(att) + MAP_W'(`MAP_ROUND_VAL);  // round to nearest.
    scaled = sum >>> `MAP_SHIFT;                                  // drop fraction.
    if (scaled >= `MOTOR_VAL_MIN && scaled <= `MOTOR_VAL_MAX) begin
      return scaled[`MOTOR_RATE_W-1:0];
    end
    return last;
  endfunction

  // ------------------------------------------------
  // output registers.
  // the output always equals the last legal rate, so one
  // register per motor serves as both.
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      motor_rates <= '0;
      rates_valid <= 1'b0;
    end else begin
      rates_valid <= att_valid;                  // thrust_valid coincides.
      if (att_valid) begin
        if (!armed) begin
          motor_rates <= '0;                     // disarmed, also clears the hold.
        end else begin
          motor_rates.m1 <= map_motor(thrust, att_mix.m1, motor_rates.m1);
          motor_rates.m2 <= map_motor(thrust, att_mix.m2, motor_rates.m2);
          motor_rates.m3 <= map_motor(thrust, att_mix.m3, motor_rates.m3);
          motor_rates.m4 <= map_motor(thrust, att_mix.m4, motor_rates.m4);
        end
      end
    end
  end

endmodule

// ==== hw/motor_mixer_top.sv ====
// ------------------------------------------------
// motor mixer top. apb registers, parallel attitude and
// thrust stages, output mapper.
// ------------------------------------------------
`timescale 1ns/10ps
`include "mixer_config.svh"

module motor_mixer_top (
  input  logic                     sys_clk,
  input  logic                     rst_n,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`APB_ADDR_W-1:0]   paddr,
  input  logic [`APB_DATA_W-1:0]   pwdata,
  output logic [`APB_DATA_W-1:0]   prdata,
  output logic                     pready,
  output logic                     pslverr,
  output mixer_pkg::motor_rates_t  motor_rates,
  output logic                     rates_valid
);
  import mixer_pkg::*;

  rate_cmd_t     cmd;          // committed rate words.
  logic          cmd_valid;    // commit pulse.
  logic          armed;        // arm state taken at commit.
  attitude_mix_t att_mix;
  logic          att_valid;
  rate_t         thrust;

  mixer_apb_regs i_regs (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .motor_rates (motor_rates),
    .cmd         (cmd),
    .cmd_valid   (cmd_valid),
    .armed       (armed)
  );

  // ------------------------------------------------
  // the two stages run side by side on each commit.
  attitude_mixer i_att (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .att_mix   (att_mix),
    .att_valid (att_valid)
  );

  collective_thrust i_thrust (
    .sys_clk      (sys_clk),
    .rst_n        (rst_n),
    .cmd          (cmd),
    .cmd_valid    (cmd_valid),
    .thrust       (thrust),
    .thrust_valid ()            // same cycle as att_valid.
  );

  motor_output_mapper i_map (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .att_mix     (att_mix),
    .att_valid   (att_valid),
    .thrust      (thrust),
    .armed       (armed),
    .motor_rates (motor_rates),
    .rates_valid (rates_valid)
  );

endmodule

// ==== verification/motor_mixer_tb.sv ====
// ------------------------------------------------
// motor mixer testbench. apb stimulus, reference model
// and assertions on the motor rate outputs.
// ------------------------------------------------
`timescale 1ns/10ps
`include "mixer_config.svh"

module motor_mixer_tb;
  import mixer_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int RANDOM_CMDS  = 200;
  localparam int TOTAL_CMDS   = RANDOM_CMDS + 20;          // random plus directed, with margin.
  localparam int WATCHDOG_NS  = (RESET_CYCLES + TOTAL_CMDS * 20) * CLK_PERIOD;

  logic                    sys_clk;
  logic                    rst_n;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [`APB_ADDR_W-1:0]  paddr;
  logic [`APB_DATA_W-1:0]  pwdata;
  logic [`APB_DATA_W-1:0]  prdata;
  logic                    pready;
  logic                    pslverr;
  motor_rates_t            motor_rates;
  logic                    rates_valid;

  logic [31:0]   lcg_state;                                // random stream state.
  rate_t         shadow_yaw;                               // model copy of the rate registers.
  rate_t         shadow_roll;
  rate_t         shadow_pitch;
  rate_t         shadow_thr;
  motor_rate_t   last_legal [4];                           // model hold values, m1 first.
  motor_rates_t  expected_q [$];                           // one entry per commit in flight.
  logic          commit_access;

  motor_mixer_top i_dut (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .motor_rates (motor_rates),
    .rates_valid (rates_valid)
  );

  always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

  // ------------------------------------------------
  // helpers.
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;               // numerical recipes constants.
  endfunction

  // throttle plus bias, clamped to the signed word range.
  function automatic rate_t thrust_model(input rate_t thr);
    int s;
    s = int'(thr) + int'(`MOTOR_RATE_BIAS);
    if (s > 32767) s = 32767;
    else if (s < -32768) s = -32768;
    return rate_t'(s);
  endfunction

  // signed sum of the halved terms, wrapped to 16 bits.
  function automatic rate_t mix_term(input int ys, input int rs, input int ps);
    int y;
    int r;
    int p;
    y = int'(shadow_yaw) >>> 1;
    r = int'(shadow_roll) >>> 1;
    p = int'(shadow_pitch) >>> 1;
    return rate_t'(ys * y + rs * r + ps * p);
  endfunction

  function automatic motor_rate_t map_model(input rate_t thr, input rate_t att,
                                            input motor_rate_t last);
    int v;
    v = (int'(thr) + int'(att) + `MAP_ROUND_VAL) >>> `MAP_SHIFT;
    if (v >= `MOTOR_VAL_MIN && v <= `MOTOR_VAL_MAX) return motor_rate_t'(v);
    return last;                                           // out of window, hold.
  endfunction

  // ------------------------------------------------
  // apb access. starts and ends just after a rising edge.
  task automatic apb_transfer(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                              input logic [`APB_DATA_W-1:0] wdata,
                              output logic [`APB_DATA_W-1:0] rdata, output logic err);
    psel    = 1'b1;                                        // setup phase.
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge sys_clk);
    #1 penable = 1'b1;                                     // access phase.
    @(negedge sys_clk);
    assert (pready)
      else stop_on_error($sformatf("FAIL pready expected %h actual %h", 1'b1, pready));
    rdata = prdata;
    err   = pslverr;
    @(posedge sys_clk);
    #1 psel = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_ok(input logic [`APB_ADDR_W-1:0] addr, input logic [`APB_DATA_W-1:0] d);
    logic [`APB_DATA_W-1:0] unused;
    logic err;
    apb_transfer(1'b1, addr, d, unused, err);
    assert (!err) else stop_on_error($sformatf("pslverr on a legal write to offset %h", addr));
  endtask

  task automatic read_expect(input logic [`APB_ADDR_W-1:0] addr,
                             input logic [`APB_DATA_W-1:0] exp);
    logic [`APB_DATA_W-1:0] data;
    logic err;
    apb_transfer(1'b0, addr, '0, data, err);
    assert (!err) else stop_on_error($sformatf("pslverr on a legal read of offset %h", addr));
    assert (data == exp)
      else stop_on_error($sformatf("FAIL prdata at %h expected %h actual %h", addr, exp, data));
  endtask

  // the upper half goes in opposite to the sign bit. readback shows the extension.
  task automatic set_rates(input rate_t y, input rate_t r, input rate_t p, input rate_t t);
    write_ok(REG_YAW, {{16{~y[15]}}, y});
    write_ok(REG_ROLL, {{16{~r[15]}}, r});
    write_ok(REG_PITCH, {{16{~p[15]}}, p});
    write_ok(REG_THROTTLE, {{16{~t[15]}}, t});
    shadow_yaw   = y;
    shadow_roll  = r;
    shadow_pitch = p;
    shadow_thr   = t;
  endtask

  // predict the result, then write ctrl with the commit bit.
  task automatic commit(input logic arm);
    rate_t thr;
    rate_t att [4];
    int m;
    thr    = thrust_model(shadow_thr);
    att[0] = mix_term(-1, 1, -1);                          // m1, ccw.
    att[1] = mix_term(1, -1, -1);                          // m2, cw.
    att[2] = mix_term(1, 1, 1);                            // m3, cw.
    att[3] = mix_term(-1, -1, 1);                          // m4, ccw.
    for (m = 0; m < 4; m++) begin
      last_legal[m] = arm ? map_model(thr, att[m], last_legal[m]) : '0;
    end
    expected_q.push_back({last_legal[0], last_legal[1], last_legal[2], last_legal[3]});
    write_ok(REG_CTRL, 32'(arm) | (32'd1 << CTRL_COMMIT_BIT));
  endtask

  task automatic drain_results();
    while (expected_q.size() != 0) begin
      @(posedge sys_clk);
      #1;
    end
  endtask

  // ------------------------------------------------
  // assertions.
  assign commit_access = psel && penable && pwrite && (paddr == REG_CTRL) &&
                         pwdata[CTRL_COMMIT_BIT];

  commit_pulses: assert property (@(posedge sys_clk) disable iff (!rst_n)
    $past(commit_access) |-> i_dut.cmd_valid)
    else stop_on_error($sformatf("FAIL cmd_valid expected %h actual %h", 1'b1, 1'b0));
  no_stray_commit: assert property (@(posedge sys_clk) disable iff (!rst_n)
    !$past(commit_access) |-> !i_dut.cmd_valid)
    else stop_on_error($sformatf("FAIL cmd_valid expected %h actual %h", 1'b0, 1'b1));
  result_latency: assert property (@(posedge sys_clk) disable iff (!rst_n)
    $past(i_dut.cmd_valid, 2) |-> rates_valid)
    else stop_on_error($sformatf("FAIL rates_valid expected %h actual %h", 1'b1, 1'b0));
  no_stray_result: assert property (@(posedge sys_clk) disable iff (!rst_n)
    !$past(i_dut.cmd_valid, 2) |-> !rates_valid)
    else stop_on_error($sformatf("FAIL rates_valid expected %h actual %h", 1'b0, 1'b1));

  // results leave in commit order.
  always @(negedge sys_clk) begin : result_check
    motor_rates_t exp_r;
    if (rst_n && rates_valid) begin
      assert (expected_q.size() != 0) else stop_on_error("motor rates came out with no commit");
      exp_r = expected_q.pop_front();
      assert (motor_rates == exp_r) else stop_on_error(
        $sformatf("FAIL motor_rates expected %h actual %h", exp_r, motor_rates));
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    stop_on_error("watchdog expired before the tests finished");
  end

  // ------------------------------------------------
  // stimulus.
  initial begin : stimulus
    logic [`APB_DATA_W-1:0] data;
    logic err;
    rate_t y;
    rate_t r;
    rate_t p;
    rate_t t;
    sys_clk   = 1'b0;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    lcg_state = 32'hd8c2_0a48;
    shadow_yaw   = '0;
    shadow_roll  = '0;
    shadow_pitch = '0;
    shadow_thr   = '0;
    last_legal   = '{default: '0};
    repeat (RESET_CYCLES) @(posedge sys_clk);
    #1 rst_n = 1'b1;

    // reset state.
    assert (!rates_valid)
      else stop_on_error($sformatf("FAIL rates_valid expected %h actual %h", 1'b0, rates_valid));
    assert (motor_rates == '0)
      else stop_on_error($sformatf("FAIL motor_rates expected %h actual %h", 32'h0, motor_rates));
    read_expect(REG_MOTORS, 32'h0);

    // readback and bus errors.
    set_rates(16'hFF38, 16'h0123, 16'h8001, 16'h7FF0);
    read_expect(REG_YAW, 32'hFFFF_FF38);
    read_expect(REG_ROLL, 32'h0000_0123);
    read_expect(REG_PITCH, 32'hFFFF_8001);
    read_expect(REG_THROTTLE, 32'h0000_7FF0);
    apb_transfer(1'b1, 8'h18, 32'h0000_0003, data, err);
    assert (err) else stop_on_error("no pslverr on a write to unmapped offset 18");
    apb_transfer(1'b0, 8'h18, '0, data, err);
    assert (err) else stop_on_error("no pslverr on a read of unmapped offset 18");
    apb_transfer(1'b1, REG_MOTORS, 32'hFFFF_FFFF, data, err);
    assert (err) else stop_on_error("no pslverr on a write to the read-only motor register");
    read_expect(REG_YAW, 32'hFFFF_FF38);
    read_expect(REG_ROLL, 32'h0000_0123);
    read_expect(REG_PITCH, 32'hFFFF_8001);
    read_expect(REG_THROTTLE, 32'h0000_7FF0);
    read_expect(REG_CTRL, 32'h0);
    read_expect(REG_MOTORS, 32'h0);

    // random commands inside the window.
    for (int i = 0; i < RANDOM_CMDS; i++) begin
      lcg_state = lcg_step(lcg_state);
      y = rate_t'(signed'(lcg_state[24:16]));            // -256 to 255.
      lcg_state = lcg_step(lcg_state);
      r = rate_t'(signed'(lcg_state[24:16]));
      lcg_state = lcg_step(lcg_state);
      p = rate_t'(signed'(lcg_state[24:16]));
      lcg_state = lcg_step(lcg_state);
      t = 16'd512 + {5'd0, lcg_state[26:16]};              // 32.0 to about 160.0.
      set_rates(y, r, p, t);
      commit(1'b1);
    end
    drain_results();
    read_expect(REG_MOTORS, {last_legal[0], last_legal[1], last_legal[2], last_legal[3]});

    // window hold. m3 above the window, m2 below it.
    set_rates(16'h0000, 16'h0820, 16'h0820, 16'h0700);
    commit(1'b1);
    // thrust saturates, only m2 lands inside the window.
    set_rates(16'h0000, 16'h7530, 16'h7530, 16'h7F80);
    commit(1'b1);
    drain_results();

    // disarm clears the outputs and the hold values.
    commit(1'b0);
    drain_results();
    read_expect(REG_MOTORS, 32'h0);
    set_rates(16'h0000, 16'h0820, 16'h0820, 16'h0700);
    commit(1'b1);
    drain_results();

    // back-to-back commits, two cycles apart.
    set_rates(16'h0040, 16'hFFA0, 16'h0030, 16'h0400);
    commit(1'b1);
    commit(1'b0);
    commit(1'b1);
    commit(1'b1);

    repeat (4) @(posedge sys_clk);
    #1;
    if (expected_q.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      stop_on_error("results still pending at the end of the run");
    end
  end

endmodule

// ==== motor_mixer_top.f ====
+incdir+hw
hw/mixer_pkg.sv
hw/mixer_apb_regs.sv
hw/attitude_mixer.sv
hw/collective_thrust.sv
hw/motor_output_mapper.sv
hw/motor_mixer_top.sv
verification/motor_mixer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the motor mixer testbench with verilator.
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f motor_mixer_top.f \
  --top-module motor_mixer_tb \
  -Mdir obj_dir

./obj_dir/Vmotor_mixer_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
